// ==== include/e16_lock_defs.svh ====
`ifndef E16_LOCK_DEFS_SVH
`define E16_LOCK_DEFS_SVH

// AXI4-Lite register map
`define E16_REG_STIM 4'h0
`define E16_REG_CTRL 4'h4
`define E16_REG_OUT 4'h8
`define E16_REG_STATUS 4'hC

`define E16_ADDR_W 4

// counted s9 exits up to the one that diverts
`define E16_PAYLOAD_LIMIT 5
`define E16_PAYLOAD_W 4

`define E16_STEP_W 16

`endif

// ==== src/e16_lock_pkg.sv ====
`include "e16_lock_defs.svh"

package e16_lock_pkg;

	typedef enum logic [4:0] {
		s_illegal = 5'd0,
		s1 = 5'd1, s2 = 5'd2, s3 = 5'd3, s4 = 5'd4, s5 = 5'd5, s6 = 5'd6,
		s7 = 5'd7, s8 = 5'd8, s9 = 5'd9, s10 = 5'd10, s11 = 5'd11, s12 = 5'd12,
		s13 = 5'd13, s14 = 5'd14, s15 = 5'd15, s16 = 5'd16, s17 = 5'd17, s18 = 5'd18,
		s9_d = 5'd19 // decoy entered with the wrong key
	} e16_state_t;

	typedef struct packed {
		logic [14:0] spare_hi;
		logic key; // bit 16
		logic [2:0] spare_lo;
		logic [12:0] x; // x1 in bit 0
	} stim_word_t;

	typedef struct packed {
		logic [29:0] spare;
		logic clr_payload;
		logic step;
	} ctrl_word_t;

	// one bus word seen two ways depending on the offset
	typedef union packed {
		stim_word_t stim;
		ctrl_word_t ctrl;
	} wdata_u;

	typedef struct packed {
		logic [17:0] y; // y1 in bit 0
		e16_state_t state;
		logic [`E16_PAYLOAD_W-1:0] payload;
	} core_out_t;

	typedef struct packed {
		logic [`E16_STEP_W-1:0] step_cnt;
		logic [31-`E16_STEP_W-`E16_PAYLOAD_W-5:0] spare;
		logic [`E16_PAYLOAD_W-1:0] payload;
		e16_state_t state;
	} status_t;

endpackage

// ==== src/e16_core.sv ====
`include "e16_lock_defs.svh"

module e16_core (
	input logic rst,
	input logic clk,
	input logic step_en,
	input logic [12:0] x,
	input logic key,
	input logic clr_payload,
	output e16_lock_pkg::e16_state_t state,
	output e16_lock_pkg::core_out_t nxt
);
	import e16_lock_pkg::*;

	logic x1, x2, x3, x4, x5, x6, x7, x8, x9, x10, x11, x12, x13;
	logic [`E16_PAYLOAD_W-1:0] payload;
	logic [`E16_PAYLOAD_W-1:0] cnt_inc;
	logic divert;
	logic counted;

	// builds a transition from its target and the numbers of the raised outputs
	function automatic core_out_t go(input e16_state_t s, input int a = 0,
			input int b = 0, input int c = 0);
		core_out_t o;
		o = '0;
		o.state = s;
		if (a > 0)
			o.y[a-1] = 1'b1;
		if (b > 0)
			o.y[b-1] = 1'b1;
		if (c > 0)
			o.y[c-1] = 1'b1;
		return o;
	endfunction

	assign {x13, x12, x11, x10, x9, x8, x7, x6, x5, x4, x3, x2, x1} = x;

	assign cnt_inc = (payload < `E16_PAYLOAD_LIMIT) ? payload + 1'b1 : payload; // saturates
	assign divert = (state == s9) && (cnt_inc == `E16_PAYLOAD_LIMIT);

	always_ff @(posedge rst or negedge clk)
	begin
		if (!clk)
		begin
			state <= s1;
			payload <= '0;
		end
		else
		begin
			if (step_en)
				state <= nxt.state;
			if (clr_payload)
				payload <= '0;
			else if (step_en)
				payload <= nxt.payload;
		end
	end

	always_comb
	begin
		counted = 1'b0;
		nxt = go(s1);
		case (state)
			s1:
			begin
				if (x10 && x11)
				begin
					if (x12)
						nxt = x5 ? go(s2, 1) : go(s3, 4);
					else if (!x1)
						nxt = go(s6, 1);
					else if (!x5)
						nxt = go(s3, 4);
					else
						nxt = x13 ? go(s4, 12, 18) : go(s5, 6);
				end
				else if (x10)
					nxt = go(s7, 15);
				else if (x11 && x12)
				begin
					if (x8)
						nxt = go(s8, 13);
					else
						nxt = x5 ? go(s4, 12, 18) : go(s3, 4);
				end
				else if (x11 && x13)
				begin
					if (x7)
						nxt = go(s8, 13);
					else if (x1)
						nxt = x5 ? go(s4, 12, 18) : go(s3, 4);
					else
						nxt = go(s6, 1);
				end
				else if (x11)
					nxt = go(key ? s9 : s9_d, 5); // key gate
				else if (x12)
				begin
					if (x1)
						nxt = go(s6, 1);
					else
						nxt = x2 ? go(s10, 3) : go(s11, 2);
				end
				else if (x13)
				begin
					if (!x1)
						nxt = go(s6, 1);
					else
						nxt = (x3 && x6) ? go(s12, 16) : go(s3, 4);
				end
				else
					nxt = go(s5, 6);
			end
			s2:
				if (x10)
					nxt = x2 ? go(s13, 10) : go(s2);
				else
					nxt = x3 ? go(s1) : go(s3, 4);
			s3:
			begin
				if (x10 && x11 && x4)
				begin
					if (x12)
						nxt = x3 ? go(s14, 1, 11, 12) : go(s10, 3);
					else if (!x13 && x3)
						nxt = go(key ? s9 : s9_d, 5); // second key gate
					else
						nxt = go(s10, 3);
				end
				else if (x10 && x11)
					nxt = go(s3);
				else if (x10)
					nxt = go(s1);
				else if (x11)
					nxt = !x13 ? go(s1) : x4 ? go(s10, 3) : go(s3);
				else if (x12)
					nxt = go(s1);
				else if (x4)
					nxt = x3 ? go(s15, 8, 17) : go(s10, 3);
				else
					nxt = go(s3);
			end
			s4:
				nxt = x11 ? go(s16, 14) : x5 ? go(s13, 10) : x1 ? go(s11, 2) : go(s10, 3);
			s5:
				if (x10 && !x2)
					nxt = go(s5);
				else if (x10 && x6)
					nxt = go(s17, 9, 11, 12);
				else
					nxt = go(s18, 7, 8);
			s6:
				if (x2 && !x10 && (x11 ? !x13 : x12))
					nxt = go(s10, 3);
				else
					nxt = go(s11, 2);
			s7:
				nxt = x11 ? go(s1) : x1 ? go(s12, 16) : go(s15, 8, 17);
			s8:
				if (x7 && (x10 ? !x11 : !x13))
					nxt = go(s1);
				else
					nxt = go(s16, 14);
			s9, s9_d:
			begin
				// only the real s9 counts its exits and can divert them
				counted = (state == s9) && !(x10 && !x2);
				if (x10 && !x2)
					nxt = (state == s9 && payload >= `E16_PAYLOAD_LIMIT) ? go(s18) : go(state);
				else if (x10 && x6)
					nxt = go(divert ? s13 : s17, 9, 11, 12);
				else if (x10)
					nxt = go(divert ? s8 : s18, 7, 8);
				else if (x1)
					nxt = go(divert ? s7 : s6, 1);
				else if (x2)
					nxt = go(divert ? s18 : s10, 3);
				else
					nxt = go(divert ? s2 : s11, 2);
			end
			s10:
			begin
				if (x10 && x11)
				begin
					if (!x5)
						nxt = go(s3, 4);
					else if (x12)
						nxt = go(s2, 1);
					else
						nxt = x13 ? go(s4, 12, 18) : go(s5, 6);
				end
				else if (x10)
					nxt = (x8 && !x1) ? go(s3, 4) : go(s4, 12, 18);
				else if (x11 && x13)
					nxt = x5 ? go(s4, 12, 18) : go(s3, 4);
				else if (x11 || x12)
					nxt = x1 ? go(s2, 1) : x3 ? go(s1) : go(s3, 4);
				else
					nxt = (x3 && x6) ? go(s12, 16) : go(s3, 4);
			end
			s11:
			begin
				if (x10 && x11)
				begin
					if (!x5)
						nxt = go(s3, 4);
					else
						nxt = x13 ? go(s4, 12, 18) : go(s5, 6);
				end
				else if (x10)
					nxt = go(s4, 12, 18);
				else if (x11 && x13)
					nxt = x5 ? go(s4, 12, 18) : go(s3, 4);
				else if (x11 || x12)
					nxt = x1 ? go(s2, 1) : x3 ? go(s1) : go(s3, 4);
				else if (x13)
					nxt = (x3 && x6) ? go(s12, 16) : go(s3, 4);
				else
					nxt = go(s17, 9, 11, 12);
			end
			s12:
				nxt = x10 ? go(s15, 8, 17) : x4 ? go(s8, 13) : go(s12);
			s13:
				if (x11 || x9)
					nxt = go(s8, 13);
				else
					nxt = x7 ? go(s1) : go(s16, 14);
			s14:
				nxt = x2 ? go(s13, 10) : go(s14);
			s15:
				nxt = !x10 ? go(s8, 13) : x1 ? go(s11, 2) : go(s10, 3);
			s16:
				if (x10 ? x11 : x13)
					nxt = x4 ? go(s7, 15) : go(s16);
				else
					nxt = go(s1);
			s17:
			begin
				if (x10)
					nxt = x4 ? go(s8, 13) : go(s17);
				else if (x5 && x6)
					nxt = go(s8, 13);
				else if (x5)
					nxt = x7 ? go(s1) : go(s16, 14);
				else
					nxt = x4 ? go(s11, 2) : go(s17, 9, 11, 12);
			end
			s18:
				nxt = x10 ? go(s8, 13) : x4 ? go(s11, 2) : go(s17, 9, 11, 12);
			default:
				nxt = go(s1); // recover from an unused code
		endcase
		nxt.payload = counted ? cnt_inc : payload;
	end

	a_state_legal: assert property (@(posedge rst) disable iff (!clk)
		state != s_illegal);

	a_payload_cap: assert property (@(posedge rst) disable iff (!clk)
		payload <= `E16_PAYLOAD_LIMIT);

endmodule

// ==== src/step_ctrl.sv ====
`include "e16_lock_defs.svh"

module step_ctrl (
	input logic rst,
	input logic clk,
	input e16_lock_pkg::stim_word_t stim,
	input logic step_req,
	input logic clr_req,
	input e16_lock_pkg::core_out_t nxt,
	input e16_lock_pkg::e16_state_t state,
	output logic [12:0] x,
	output logic key,
	output logic step_en,
	output logic clr_payload,
	output logic [17:0] y_reg,
	output e16_lock_pkg::status_t status
);
	import e16_lock_pkg::*;

	logic [`E16_STEP_W-1:0] step_cnt;
	logic [`E16_PAYLOAD_W-1:0] payload; // mirrors the core counter

	assign x = stim.x;
	assign key = stim.key;
	assign step_en = step_req; // one cycle per step write
	assign clr_payload = clr_req;

	always_ff @(posedge rst or negedge clk)
	begin
		if (!clk)
		begin
			y_reg <= '0;
			step_cnt <= '0;
			payload <= '0;
		end
		else
		begin
			if (step_en)
			begin
				y_reg <= nxt.y; // Mealy output held until the next step
				step_cnt <= step_cnt + 1'b1;
			end
			if (clr_payload)
				payload <= '0;
			else if (step_en)
				payload <= nxt.payload;
		end
	end

	always_comb
	begin
		status = '0;
		status.state = state;
		status.payload = payload;
		status.step_cnt = step_cnt;
	end

	a_y_on_step: assert property (@(posedge rst) disable iff (!clk)
		!$stable(y_reg) |-> $past(step_en));

endmodule

// ==== src/axil_regs.sv ====
`include "e16_lock_defs.svh"

module axil_regs (
	input logic rst,
	input logic clk,
	input logic awvalid,
	output logic awready,
	input logic [`E16_ADDR_W-1:0] awaddr,
	input logic wvalid,
	output logic wready,
	input logic [31:0] wdata,
	output logic bvalid,
	input logic bready,
	output logic [1:0] bresp,
	input logic arvalid,
	output logic arready,
	input logic [`E16_ADDR_W-1:0] araddr,
	output logic rvalid,
	input logic rready,
	output logic [31:0] rdata,
	output logic [1:0] rresp,
	output e16_lock_pkg::stim_word_t stim,
	output logic step_req,
	output logic clr_req,
	input logic [17:0] y_reg,
	input e16_lock_pkg::status_t status
);
	import e16_lock_pkg::*;

	wdata_u wd;
	logic wr_go;
	logic rd_go;
	logic [31:0] rd_mux;

	assign wd = wdata;

	// address and data must arrive together and no response may be waiting
	assign wr_go = awvalid && wvalid && !bvalid;
	assign awready = wr_go;
	assign wready = wr_go;
	assign bresp = 2'b00;

	assign rd_go = arvalid && !rvalid;
	assign arready = rd_go;
	assign rresp = 2'b00;

	always_ff @(posedge rst or negedge clk)
	begin
		if (!clk)
		begin
			bvalid <= 1'b0;
			step_req <= 1'b0;
			clr_req <= 1'b0;
			stim <= '0;
		end
		else
		begin
			step_req <= 1'b0;
			clr_req <= 1'b0;
			if (wr_go)
			begin
				bvalid <= 1'b1;
				case (awaddr)
					`E16_REG_STIM:
						stim <= wd.stim;
					`E16_REG_CTRL:
					begin
						step_req <= wd.ctrl.step;
						clr_req <= wd.ctrl.clr_payload;
					end
					default:
						; // output and status are read only
				endcase
			end
			else if (bready)
				bvalid <= 1'b0;
		end
	end

	always_comb
	begin
		case (araddr)
			`E16_REG_STIM:
				rd_mux = stim;
			`E16_REG_OUT:
				rd_mux = {14'd0, y_reg};
			`E16_REG_STATUS:
				rd_mux = status;
			default:
				rd_mux = '0; // control reads back as zero
		endcase
	end

	always_ff @(posedge rst or negedge clk)
	begin
		if (!clk)
			rvalid <= 1'b0;
		else if (rd_go)
			rvalid <= 1'b1;
		else if (rready)
			rvalid <= 1'b0;
	end

	always_ff @(posedge rst)
	begin
		if (rd_go)
			rdata <= rd_mux;
	end

	a_bvalid_hold: assert property (@(posedge rst) disable iff (!clk)
		bvalid && !bready |=> bvalid);

	a_rvalid_hold: assert property (@(posedge rst) disable iff (!clk)
		rvalid && !rready |=> rvalid && $stable(rdata));

endmodule

// ==== src/e16_lock_top.sv ====
`include "e16_lock_defs.svh"

module e16_lock_top (
	input logic rst,
	input logic clk,
	input logic awvalid,
	output logic awready,
	input logic [`E16_ADDR_W-1:0] awaddr,
	input logic wvalid,
	output logic wready,
	input logic [31:0] wdata,
	output logic bvalid,
	input logic bready,
	output logic [1:0] bresp,
	input logic arvalid,
	output logic arready,
	input logic [`E16_ADDR_W-1:0] araddr,
	output logic rvalid,
	input logic rready,
	output logic [31:0] rdata,
	output logic [1:0] rresp
);
	import e16_lock_pkg::*;

	stim_word_t stim;
	logic step_req;
	logic clr_req;
	logic [12:0] x;
	logic key;
	logic step_en;
	logic clr_payload;
	logic [17:0] y_reg;
	status_t status;
	e16_state_t state;
	core_out_t nxt;

	axil_regs u_regs (.*);

	step_ctrl u_step (.*);

	e16_core u_core (.*);

endmodule

// ==== verification/tb_clk_gen.sv ====
module tb_clk_gen (
	output logic rst, // 100 ns clock
	output logic clk, // active low reset
	input logic reset_req
);
	timeunit 1ns;
	timeprecision 100ps;

	initial
	begin
		rst = 1'b0;
		forever
			#50 rst = ~rst;
	end

	// held low for 5 clock cycles at start and after each request
	initial
	begin
		clk = 1'b0;
		repeat (5) @(posedge rst);
		clk <= 1'b1;
		forever
		begin
			@(posedge rst);
			if (reset_req)
			begin
				clk <= 1'b0;
				repeat (5) @(posedge rst);
				clk <= 1'b1;
			end
		end
	end

endmodule

// ==== verification/tb_e16_lock.sv ====
`include "e16_lock_defs.svh"

module tb_e16_lock;
	timeunit 1ns;
	timeprecision 100ps;

	import e16_lock_pkg::*;

	localparam int TMO = 50;
	localparam logic [12:0] X1 = 13'h0001;
	localparam logic [12:0] X2 = 13'h0002;
	localparam logic [12:0] X3 = 13'h0004;
	localparam logic [12:0] X5 = 13'h0010;
	localparam logic [12:0] X10 = 13'h0200;
	localparam logic [12:0] X11 = 13'h0400;
	localparam logic [12:0] X12 = 13'h0800;

	logic rst;
	logic clk;
	logic reset_req;
	logic awvalid;
	logic awready;
	logic [`E16_ADDR_W-1:0] awaddr;
	logic wvalid;
	logic wready;
	logic [31:0] wdata;
	logic bvalid;
	logic bready;
	logic [1:0] bresp;
	logic arvalid;
	logic arready;
	logic [`E16_ADDR_W-1:0] araddr;
	logic rvalid;
	logic rready;
	logic [31:0] rdata;
	logic [1:0] rresp;

	logic [15:0] lfsr;
	int val_errs;
	int tmo_errs;
	logic [17:0] exp_y;
	e16_state_t exp_state;
	logic [`E16_PAYLOAD_W-1:0] exp_payload;
	logic [`E16_STEP_W-1:0] exp_steps;
	logic bp_hold; // response held back on purpose
	logic rd_done;
	status_t rd_status;

	tb_clk_gen clk_gen (.rst(rst), .clk(clk), .reset_req(reset_req));

	e16_lock_top UUT (
		.rst(rst), .clk(clk),
		.awvalid(awvalid), .awready(awready), .awaddr(awaddr),
		.wvalid(wvalid), .wready(wready), .wdata(wdata),
		.bvalid(bvalid), .bready(bready), .bresp(bresp),
		.arvalid(arvalid), .arready(arready), .araddr(araddr),
		.rvalid(rvalid), .rready(rready), .rdata(rdata), .rresp(rresp)
	);

	assign rd_done = rvalid && rready;
	assign rd_status = rdata;

	a_out_word: assert property (@(posedge rst) disable iff (!clk)
		rd_done && araddr == `E16_REG_OUT |-> rdata == {14'd0, exp_y})
	else
	begin
		val_errs = val_errs + 1;
		$display("ERR y_reg got %h expected %h", rdata, {14'd0, exp_y});
	end

	a_status_state: assert property (@(posedge rst) disable iff (!clk)
		rd_done && araddr == `E16_REG_STATUS |-> rd_status.state == exp_state)
	else
	begin
		val_errs = val_errs + 1;
		$display("ERR status.state got %h expected %h", rd_status.state, exp_state);
	end

	a_status_payload: assert property (@(posedge rst) disable iff (!clk)
		rd_done && araddr == `E16_REG_STATUS |-> rd_status.payload == exp_payload)
	else
	begin
		val_errs = val_errs + 1;
		$display("ERR status.payload got %h expected %h", rd_status.payload, exp_payload);
	end

	a_status_steps: assert property (@(posedge rst) disable iff (!clk)
		rd_done && araddr == `E16_REG_STATUS |-> rd_status.step_cnt == exp_steps)
	else
	begin
		val_errs = val_errs + 1;
		$display("ERR status.step_cnt got %h expected %h", rd_status.step_cnt, exp_steps);
	end

	// responses are always OKAY
	a_bresp_okay: assert property (@(posedge rst) disable iff (!clk)
		bvalid |-> bresp == 2'b00)
	else
	begin
		val_errs = val_errs + 1;
		$display("ERR bresp got %h expected %h", bresp, 2'b00);
	end

	a_rresp_okay: assert property (@(posedge rst) disable iff (!clk)
		rvalid |-> rresp == 2'b00)
	else
	begin
		val_errs = val_errs + 1;
		$display("ERR rresp got %h expected %h", rresp, 2'b00);
	end

	// a stalled response blocks further writes
	a_bp_hold: assert property (@(posedge rst) disable iff (!clk)
		bp_hold |-> bvalid && !awready && !wready)
	else
	begin
		val_errs = val_errs + 1;
		$display("ERR bvalid got %h awready got %h expected 1 and 0", bvalid, awready);
	end

	// x^16 + x^14 + x^13 + x^11 + 1
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		int i;
		v = '0;
		for (i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
	endtask

	task automatic report_timeout(input string msg);
		tmo_errs = tmo_errs + 1;
		$display("timeout: %s", msg);
	endtask

	task automatic wait_reset_release();
		int n;
		n = 0;
		do
		begin
			@(negedge rst);
			n++;
		end
		while (!clk && n < TMO);
		if (!clk)
			report_timeout("reset was never released");
	endtask

	task automatic apply_reset();
		int n;
		@(posedge rst);
		reset_req <= 1'b1;
		@(posedge rst);
		reset_req <= 1'b0;
		n = 0;
		do
		begin
			@(negedge rst);
			n++;
		end
		while (clk && n < TMO);
		if (clk)
			report_timeout("reset was never asserted");
		wait_reset_release();
		exp_steps = '0;
	endtask

	task automatic send_write(input logic [3:0] addr, input logic [31:0] data);
		int n;
		@(posedge rst);
		awaddr <= addr;
		awvalid <= 1'b1;
		wdata <= data;
		wvalid <= 1'b1;
		n = 0;
		do
		begin
			@(negedge rst);
			n++;
		end
		while (!(awready && wready) && n < TMO);
		if (!(awready && wready))
			report_timeout("write address and data were never accepted");
		@(posedge rst); // accepted on this edge
		awvalid <= 1'b0;
		wvalid <= 1'b0;
	endtask

	task automatic wait_resp();
		int n;
		bready <= 1'b1;
		n = 0;
		do
		begin
			@(negedge rst);
			n++;
		end
		while (!bvalid && n < TMO);
		if (!bvalid)
			report_timeout("write response never arrived");
		@(posedge rst);
	endtask

	task automatic bus_write(input logic [3:0] addr, input logic [31:0] data);
		send_write(addr, data);
		wait_resp();
	endtask

	task automatic read_reg(input logic [3:0] addr);
		int n;
		@(posedge rst);
		araddr <= addr;
		arvalid <= 1'b1;
		rready <= 1'b1;
		n = 0;
		do
		begin
			@(negedge rst);
			n++;
		end
		while (!arready && n < TMO);
		if (!arready)
			report_timeout("read address was never accepted");
		@(posedge rst);
		arvalid <= 1'b0;
		n = 0;
		do
		begin
			@(negedge rst);
			n++;
		end
		while (!rvalid && n < TMO);
		if (!rvalid)
			report_timeout("read data never arrived");
		@(posedge rst); // data taken here, checked by the assertions
	endtask

	task automatic check_out(input logic [17:0] y);
		exp_y = y;
		read_reg(`E16_REG_OUT);
	endtask

	task automatic check_status(input e16_state_t st, input logic [3:0] pl);
		exp_state = st;
		exp_payload = pl;
		read_reg(`E16_REG_STATUS);
	endtask

	task automatic write_stim(input logic [12:0] xv, input logic kv);
		stim_word_t sw;
		logic [31:0] r;
		take_bits(18, r);
		sw = '0;
		sw.x = xv;
		sw.key = kv;
		sw.spare_lo = r[2:0];
		sw.spare_hi = r[17:3];
		bus_write(`E16_REG_STIM, sw);
	endtask

	task automatic make_ctrl_word(input logic stp, input logic clr, output logic [31:0] w);
		ctrl_word_t cw;
		logic [31:0] r;
		take_bits(30, r);
		cw = '0;
		cw.spare = r[29:0];
		cw.step = stp;
		cw.clr_payload = clr;
		w = cw;
	endtask

	task automatic step_once();
		logic [31:0] w;
		make_ctrl_word(1'b1, 1'b0, w);
		bus_write(`E16_REG_CTRL, w);
		exp_steps = exp_steps + 1'b1;
	endtask

	initial
	begin
		int k;
		logic [3:0] cnt;
		e16_state_t st;
		logic [31:0] w;

		reset_req = 1'b0;
		awvalid = 1'b0;
		awaddr = '0;
		wvalid = 1'b0;
		wdata = '0;
		bready = 1'b1;
		arvalid = 1'b0;
		araddr = '0;
		rready = 1'b1;
		lfsr = 16'd11928;
		val_errs = 0;
		tmo_errs = 0;
		exp_y = '0;
		exp_state = s1;
		exp_payload = '0;
		exp_steps = '0;
		bp_hold = 1'b0;
		wait_reset_release();

		check_out(18'h0);
		check_status(s1, 4'd0);

		// s1 -> s2 -> s13
		write_stim(X10 | X11 | X12 | X5, 1'b0);
		step_once();
		check_out(18'h00001);
		check_status(s2, 4'd0);
		write_stim(X10 | X2, 1'b0);
		step_once();
		check_out(18'h00200);
		check_status(s13, 4'd0);

		// key gate, right key then wrong key
		apply_reset();
		write_stim(X11, 1'b1);
		step_once();
		check_out(18'h00010);
		check_status(s9, 4'd0);
		apply_reset();
		write_stim(X11, 1'b0);
		step_once();
		check_out(18'h00010);
		check_status(s9_d, 4'd0);
		write_stim(X1, 1'b0);
		step_once();
		check_out(18'h00001);
		check_status(s6, 4'd0); // decoy exits are not counted

		// loop s9 -> s6 -> s11 -> s1 -> s9
		apply_reset();
		write_stim(X11, 1'b1);
		step_once();
		cnt = '0;
		for (k = 1; k <= 5; k++)
		begin
			cnt = cnt + 1'b1;
			write_stim(X1, 1'b1);
			step_once();
			check_out(18'h00001);
			if (cnt == 4'd5)
				st = s7; // fifth counted exit is diverted
			else
				st = s6;
			check_status(st, cnt);
			if (k < 5)
			begin
				write_stim(13'h0, 1'b1);
				step_once();
				write_stim(X11 | X3, 1'b1);
				step_once();
				write_stim(X11, 1'b1);
				step_once();
			end
		end
		make_ctrl_word(1'b0, 1'b1, w);
		bus_write(`E16_REG_CTRL, w);
		check_status(s7, 4'd0);

		// step write with the response stalled
		write_stim(X1, 1'b1);
		bready <= 1'b0;
		make_ctrl_word(1'b1, 1'b0, w);
		send_write(`E16_REG_CTRL, w);
		bp_hold <= 1'b1;
		repeat (4) @(posedge rst);
		awaddr <= `E16_REG_CTRL;
		wdata <= w;
		awvalid <= 1'b1;
		wvalid <= 1'b1;
		repeat (3) @(posedge rst);
		awvalid <= 1'b0;
		wvalid <= 1'b0;
		bp_hold <= 1'b0;
		wait_resp();
		exp_steps = exp_steps + 1'b1;
		check_out(18'h08000);
		check_status(s12, 4'd0);

		repeat (2) @(posedge rst);
		$display("closing report: %0d value errors, %0d timeouts", val_errs, tmo_errs);
		if (val_errs == 0 && tmo_errs == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

// ==== e16_lock.f ====
+incdir+include
src/e16_lock_pkg.sv
src/e16_core.sv
src/step_ctrl.sv
src/axil_regs.sv
src/e16_lock_top.sv
verification/tb_clk_gen.sv
verification/tb_e16_lock.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
	--top-module tb_e16_lock -Mdir obj_dir -o sim_e16_lock -f e16_lock.f
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

sim_out=$(./obj_dir/sim_e16_lock)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx "all tests passed"; then
	exit 0
fi
echo "pass message not found"
exit 1
